/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= engine_read_write_tb
FILELIST  ?= vlog.f
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* hdl/config_store.sv */
`timescale 1ns/100ps
/*
 * Configuration store
 * Captures start index, count and stride from config responses
 */
module config_store (
    input  logic                         ap_clk,
    input  logic                         areset_read_write_engine,
    input  logic                         clear,
    input  read_write_pkg::mem_packet_t  response_in,
    output read_write_pkg::read_config_t read_config,
    output logic                         cfg_complete
);
    import read_write_pkg::*;

    config_word_sel_t sel;
    logic [2:0]       received;

    // Word offset from the config base, base assumed aligned to four words
    assign sel = config_word_sel_t'(response_in.address[1:0]);

    // Mask of fields received in this job
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine || clear) begin
            received <= '0;
        end else if (response_in.valid) begin
            case (sel)
                cfg_index_start: received[0] <= 1'b1;
                cfg_count:       received[1] <= 1'b1;
                cfg_stride:      received[2] <= 1'b1;
                default:         received    <= received;
            endcase
        end
    end

    // Field registers
    always_ff @(posedge ap_clk) begin
        if (response_in.valid) begin
            case (sel)
                cfg_index_start: read_config.index_start <= addr_width'(response_in.data);
                cfg_count:       read_config.count       <= response_in.data;
                cfg_stride:      read_config.stride      <= addr_width'(response_in.data);
                default:         read_config             <= read_config;
            endcase
        end
    end

    // All three words in
    assign cfg_complete = &received;

endmodule

/* hdl/engine_read_write.sv */
`timescale 1ns/100ps
/*
 * Read engine top level
 * Input, reset and output registers around control and datapath
 */
module engine_read_write #(
    parameter int fifo_depth = 16
) (
    input  logic                        ap_clk,
    input  logic                        areset,
    input  read_write_pkg::descriptor_t descriptor_in,
    input  read_write_pkg::mem_packet_t response_memory_in,
    output logic                        response_memory_ready,
    output read_write_pkg::mem_packet_t request_memory_out,
    input  logic                        request_memory_ready,
    output read_write_pkg::mem_packet_t request_engine_out,
    input  logic                        request_engine_ready,
    output logic                        done_out
);
    import read_write_pkg::*;

    logic                  areset_read_write_engine;
    descriptor_t           descriptor_reg;
    mem_packet_t           response_memory_reg;
    logic                  request_memory_ready_reg;
    logic                  request_engine_ready_reg;
    logic [addr_width-1:0] config_base;
    logic                  between_jobs;
    phase_t                phase;
    read_config_t          read_config;
    logic                  cfg_complete, all_issued, all_forwarded, control_done;
    mem_packet_t           config_packet, data_packet, response_head;
    mem_packet_t           generator_request, request_head, engine_request;
    logic                  router_ready, response_full, response_empty, response_pop;
    logic                  request_full, request_empty;

    // ----------------------------------------------------------------------
    // Reset and input registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_read_write_engine <= areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            descriptor_reg.valid      <= 1'b0;
            response_memory_reg.valid <= 1'b0;
            request_memory_ready_reg  <= 1'b0;
            request_engine_ready_reg  <= 1'b0;
        end else begin
            descriptor_reg.valid      <= descriptor_in.valid;
            response_memory_reg.valid <= response_memory_in.valid;
            request_memory_ready_reg  <= request_memory_ready;
            request_engine_ready_reg  <= request_engine_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_reg.config_base    <= descriptor_in.config_base;
        response_memory_reg.address   <= response_memory_in.address;
        response_memory_reg.data      <= response_memory_in.data;
        response_memory_reg.module_id <= response_memory_in.module_id;
    end

    // Config base held for the whole job
    assign between_jobs = (phase == phase_idle) || (phase == phase_done);

    always_ff @(posedge ap_clk) begin
        if (descriptor_reg.valid && between_jobs) begin
            config_base <= descriptor_reg.config_base;
        end
    end

    // ----------------------------------------------------------------------
    // Control and datapath
    // ----------------------------------------------------------------------
    read_write_control u_control (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .descriptor_valid        (descriptor_reg.valid),
        .cfg_complete            (cfg_complete),
        .all_issued              (all_issued),
        .all_forwarded           (all_forwarded),
        .queues_empty            (request_empty && response_empty),
        .phase                   (phase),
        .done_out                (control_done)
    );

    response_router u_router (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .response_in             (response_memory_reg),
        .data_full               (response_full),
        .config_out              (config_packet),
        .data_out                (data_packet),
        .response_ready          (router_ready)
    );

    // Mask cleared between jobs
    config_store u_config_store (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .clear                   (between_jobs),
        .response_in             (config_packet),
        .read_config             (read_config),
        .cfg_complete            (cfg_complete)
    );

    // Data responses waiting for the engine
    packet_fifo #(
        .fifo_depth(fifo_depth),
        .payload_t (mem_packet_t)
    ) u_response_fifo (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .push                    (data_packet.valid),
        .push_data               (data_packet),
        .pop                     (response_pop),
        .pop_data                (response_head),
        .full                    (response_full),
        .empty                   (response_empty)
    );

    request_generator u_generator (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .phase                   (phase),
        .config_base             (config_base),
        .read_config             (read_config),
        .request_out             (generator_request),
        .request_full            (request_full),
        .response_in             (response_head),
        .response_empty          (response_empty),
        .response_pop            (response_pop),
        .engine_request_out      (engine_request),
        .engine_ready            (request_engine_ready_reg),
        .all_issued              (all_issued),
        .all_forwarded           (all_forwarded)
    );

    // Memory requests waiting for memory ready
    packet_fifo #(
        .fifo_depth(fifo_depth),
        .payload_t (mem_packet_t)
    ) u_request_fifo (
        .ap_clk                  (ap_clk),
        .areset_read_write_engine(areset_read_write_engine),
        .push                    (generator_request.valid),
        .push_data               (generator_request),
        .pop                     (request_memory_ready_reg),
        .pop_data                (request_head),
        .full                    (request_full),
        .empty                   (request_empty)
    );

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            request_memory_out.valid <= 1'b0;
            request_engine_out.valid <= 1'b0;
            response_memory_ready    <= 1'b0;
            done_out                 <= 1'b0;
        end else begin
            request_memory_out.valid <= request_memory_ready_reg && !request_empty;
            request_engine_out.valid <= engine_request.valid;
            response_memory_ready    <= router_ready;
            done_out                 <= control_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_memory_out.address   <= request_head.address;
        request_memory_out.data      <= request_head.data;
        request_memory_out.module_id <= request_head.module_id;
        request_engine_out.address   <= engine_request.address;
        request_engine_out.data      <= engine_request.data;
        request_engine_out.module_id <= engine_request.module_id;
    end

endmodule

/* hdl/packet_fifo.sv */
`timescale 1ns/100ps
/*
 * Synchronous FIFO for any packed payload
 * Circular buffer with occupancy count, head visible on pop_data
 */
module packet_fifo #(
    parameter int  fifo_depth = 16,
    parameter type payload_t  = logic
) (
    input  logic     ap_clk,
    input  logic     areset_read_write_engine,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    // Slots kept free for packets already in flight when full rises
    localparam int reserve   = 4;
    localparam int ptr_width = $clog2(fifo_depth);
    localparam int cnt_width = $clog2(fifo_depth + 1);

    payload_t             mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    // Wrap at the depth, not at the pointer width
    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        next_ptr = (ptr == ptr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Writes into the reserve are still accepted
    assign do_push  = push && (count < cnt_width'(fifo_depth));
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count >= cnt_width'(fifo_depth - reserve));
    assign pop_data = mem[rd_ptr];

    // Storage
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/read_write_control.sv */
`timescale 1ns/100ps
/*
 * Job control FSM
 * Idle, config, run, drain and done phases, plus the done flag
 */
module read_write_control (
    input  logic                   ap_clk,
    input  logic                   areset_read_write_engine,
    input  logic                   descriptor_valid,
    input  logic                   cfg_complete,
    input  logic                   all_issued,
    input  logic                   all_forwarded,
    input  logic                   queues_empty,
    output read_write_pkg::phase_t phase,
    output logic                   done_out
);
    import read_write_pkg::*;

    phase_t phase_next;
    logic   start;

    // Descriptors only count between jobs
    assign start = descriptor_valid && ((phase == phase_idle) || (phase == phase_done));

    // ----------------------------------------------------------------------
    // Next phase
    // ----------------------------------------------------------------------
    always_comb begin
        phase_next = phase;
        case (phase)
            phase_idle, phase_done: begin
                if (start) phase_next = phase_config;
            end
            phase_config: begin
                if (cfg_complete) phase_next = phase_run;
            end
            phase_run: begin
                if (all_issued) phase_next = phase_drain;
            end
            phase_drain: begin
                if (all_forwarded && queues_empty) phase_next = phase_done;
            end
            default: phase_next = phase_idle;
        endcase
    end

    // State and done flag
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            phase    <= phase_idle;
            done_out <= 1'b0;
        end else begin
            phase <= phase_next;
            if (start) begin
                done_out <= 1'b0;
            end else if ((phase == phase_drain) && (phase_next == phase_done)) begin
                done_out <= 1'b1;
            end
        end
    end

endmodule

/* hdl/read_write_pkg.sv */
/*
 * Sizes shared by the read engine
 * Memory packet, kernel descriptor and configuration record types
 * Job phase encoding for the control FSM
 */
package read_write_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // Consumer tag carried by every memory packet
    typedef logic module_id_t;

    localparam module_id_t config_module_id = 1'b0;
    localparam module_id_t data_module_id   = 1'b1;

    // ----------------------------------------------------------------------
    // Packets and descriptor
    // ----------------------------------------------------------------------
    // Same layout for memory requests, memory responses and engine requests
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] address;
        logic [data_width-1:0] data;
        module_id_t            module_id;
    } mem_packet_t;

    // Job start strobe, points at the first configuration word
    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] config_base;
    } descriptor_t;

    // Word select from the low address bits of a config response
    typedef enum logic [1:0] {
        cfg_index_start = 2'd0,
        cfg_count       = 2'd1,
        cfg_stride      = 2'd2
    } config_word_sel_t;

    typedef struct packed {
        logic [addr_width-1:0] index_start;
        logic [data_width-1:0] count;
        logic [addr_width-1:0] stride;
    } read_config_t;

    // Control FSM states
    typedef enum logic [2:0] {
        phase_idle   = 3'd0,
        phase_config = 3'd1,
        phase_run    = 3'd2,
        phase_drain  = 3'd3,
        phase_done   = 3'd4
    } phase_t;

endpackage

/* hdl/request_generator.sv */
`timescale 1ns/100ps
/*
 * Request generator
 * Config reads, strided data reads, forwarding of data to the engine
 * Counters for issued and forwarded items
 */
module request_generator (
    input  logic                                  ap_clk,
    input  logic                                  areset_read_write_engine,
    input  read_write_pkg::phase_t                phase,
    input  logic [read_write_pkg::addr_width-1:0] config_base,
    input  read_write_pkg::read_config_t          read_config,
    output read_write_pkg::mem_packet_t           request_out,
    input  logic                                  request_full,
    input  read_write_pkg::mem_packet_t           response_in,
    input  logic                                  response_empty,
    output logic                                  response_pop,
    output read_write_pkg::mem_packet_t           engine_request_out,
    input  logic                                  engine_ready,
    output logic                                  all_issued,
    output logic                                  all_forwarded
);
    import read_write_pkg::*;

    logic [1:0]            cfg_issued;
    logic [data_width-1:0] data_issued;
    logic [data_width-1:0] forwarded;
    logic [addr_width-1:0] data_addr;
    logic                  cfg_req;
    logic                  data_req;

    // ----------------------------------------------------------------------
    // Memory requests
    // ----------------------------------------------------------------------
    // Three config reads, then one read per item, both held off by a full queue
    assign cfg_req  = (phase == phase_config) && (cfg_issued != 2'd3) && !request_full;
    assign data_req = (phase == phase_run) && !all_issued && !request_full;

    always_comb begin
        request_out.valid     = cfg_req || data_req;
        request_out.address   = cfg_req ? config_base + addr_width'(cfg_issued) : data_addr;
        request_out.data      = '0;
        request_out.module_id = cfg_req ? config_module_id : data_module_id;
    end

    // ----------------------------------------------------------------------
    // Engine forwarding
    // ----------------------------------------------------------------------
    // Queue head goes straight out, same address and data
    assign response_pop = engine_ready && !response_empty;

    always_comb begin
        engine_request_out       = response_in;
        engine_request_out.valid = response_pop;
    end

    assign all_issued    = (data_issued == read_config.count);
    assign all_forwarded = (forwarded == read_config.count);

    // Counters, restarted for every job
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            cfg_issued  <= '0;
            data_issued <= '0;
            forwarded   <= '0;
        end else begin
            if (phase != phase_config) begin
                cfg_issued <= '0;
            end else if (cfg_req) begin
                cfg_issued <= cfg_issued + 1'b1;
            end
            if (phase == phase_config) begin
                data_issued <= '0;
                forwarded   <= '0;
            end else begin
                if (data_req) begin
                    data_issued <= data_issued + 1'b1;
                end
                if (response_pop) begin
                    forwarded <= forwarded + 1'b1;
                end
            end
        end
    end

    // Running data address, loaded while the config arrives
    always_ff @(posedge ap_clk) begin
        if (phase == phase_config) begin
            data_addr <= read_config.index_start;
        end else if (data_req) begin
            data_addr <= data_addr + read_config.stride;
        end
    end

endmodule

/* hdl/response_router.sv */
`timescale 1ns/100ps
/*
 * Memory response router
 * Registers each response and steers it by module tag
 */
module response_router (
    input  logic                        ap_clk,
    input  logic                        areset_read_write_engine,
    input  read_write_pkg::mem_packet_t response_in,
    input  logic                        data_full,
    output read_write_pkg::mem_packet_t config_out,
    output read_write_pkg::mem_packet_t data_out,
    output logic                        response_ready
);
    import read_write_pkg::*;

    mem_packet_t response_reg;

    // Response valid
    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            response_reg.valid <= 1'b0;
        end else begin
            response_reg.valid <= response_in.valid;
        end
    end

    // Response payload
    always_ff @(posedge ap_clk) begin
        response_reg.address   <= response_in.address;
        response_reg.data      <= response_in.data;
        response_reg.module_id <= response_in.module_id;
    end

    // ----------------------------------------------------------------------
    // Steering
    // ----------------------------------------------------------------------
    always_comb begin
        config_out       = response_reg;
        data_out         = response_reg;
        config_out.valid = response_reg.valid && (response_reg.module_id == config_module_id);
        data_out.valid   = response_reg.valid && (response_reg.module_id == data_module_id);
    end

    // Memory may send while the data queue has room
    assign response_ready = !data_full;

endmodule

/* tests/engine_read_write_tb.sv */
`timescale 1ns/100ps
/*
 * Testbench for the read engine
 * Clock, reset, memory model with random delay and reordering
 * Job table applied in a loop, compare tasks and a watchdog
 */
module engine_read_write_tb;
    import read_write_pkg::*;

    // Job record with config words and ready duty in percent
    typedef struct packed {
        logic [31:0] config_base;
        logic [31:0] start;
        logic [31:0] count;
        logic [31:0] stride;
        logic [31:0] duty;
    } job_t;

    localparam int n_jobs = 5;

    // Config bases aligned to four words and a zero count in the middle
    job_t job_table [n_jobs] = '{
        '{32'h0000_1000, 32'h0000_0100, 32'd8,  32'd1,  32'd100},
        '{32'h0000_2004, 32'h0004_0000, 32'd20, 32'd4,  32'd50},
        '{32'h0000_3ff0, 32'h0010_0020, 32'd0,  32'd2,  32'd70},
        '{32'h0000_0040, 32'hfff0_0000, 32'd24, 32'h10, 32'd30},
        '{32'h0008_0010, 32'h0000_7777, 32'd5,  32'd3,  32'd90}
    };

    logic        ap_clk;
    logic        areset;
    descriptor_t descriptor_in;
    mem_packet_t response_memory_in;
    logic        response_memory_ready;
    mem_packet_t request_memory_out;
    logic        request_memory_ready;
    mem_packet_t request_engine_out;
    logic        request_engine_ready;
    logic        done_out;

    // Scoreboard and memory model state
    mem_packet_t exp_mem_q [$];
    mem_packet_t exp_eng_q [$];
    mem_packet_t pend_pkt [$];
    int unsigned pend_due [$];
    int unsigned eng_remaining;
    int unsigned cycle;
    int unsigned cur_duty;
    int          cur_job;
    logic        job_active;

    engine_read_write #(
        .fifo_depth(16)
    ) u_dut (
        .ap_clk               (ap_clk),
        .areset               (areset),
        .descriptor_in        (descriptor_in),
        .response_memory_in   (response_memory_in),
        .response_memory_ready(response_memory_ready),
        .request_memory_out   (request_memory_out),
        .request_memory_ready (request_memory_ready),
        .request_engine_out   (request_engine_out),
        .request_engine_ready (request_engine_ready),
        .done_out             (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("%0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_packet(input string name, input mem_packet_t actual,
                                input mem_packet_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    function automatic mem_packet_t make_packet(input logic [31:0] address,
                                                input logic [31:0] data,
                                                input module_id_t id);
        mem_packet_t pkt;
        pkt.valid     = 1'b1;
        pkt.address   = address;
        pkt.data      = data;
        pkt.module_id = id;
        return pkt;
    endfunction

    // Config words of the running job by offset from its base
    function automatic logic [31:0] config_word(input logic [31:0] address);
        logic [31:0] offset;
        offset = address - job_table[cur_job].config_base;
        case (offset)
            32'd0:   config_word = job_table[cur_job].start;
            32'd1:   config_word = job_table[cur_job].count;
            32'd2:   config_word = job_table[cur_job].stride;
            default: config_word = '0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Memory model and output monitors
    // ----------------------------------------------------------------------
    // Every request gets a response after 1 to 8 cycles
    task automatic accept_memory_request(input mem_packet_t req);
        mem_packet_t rsp;
        if (exp_mem_q.size() == 0) begin
            report_problem("memory request seen when none was expected");
        end else begin
            check_packet("request_memory_out", req, exp_mem_q.pop_front());
            rsp = req;
            if (req.module_id == config_module_id)
                rsp.data = config_word(req.address);
            else
                rsp.data = req.address ^ 32'h5a5a_0000;
            pend_pkt.push_back(rsp);
            pend_due.push_back(cycle + 1 + ($urandom % 8));
        end
    endtask

    task automatic accept_engine_request(input mem_packet_t req);
        if (exp_eng_q.size() == 0) begin
            report_problem("engine request seen with no data response behind it");
        end else begin
            check_packet("request_engine_out", req, exp_eng_q.pop_front());
            eng_remaining--;
        end
    endtask

    // Random pick among matured responses so that tags come back out of order
    task automatic send_response();
        int unsigned n_due;
        int unsigned pick;
        int          idx;
        n_due = 0;
        idx   = -1;
        response_memory_in = '0;
        if (response_memory_ready === 1'b1) begin
            foreach (pend_due[i]) begin
                if (pend_due[i] <= cycle) n_due++;
            end
            if (n_due != 0) begin
                pick = $urandom % n_due;
                for (int i = 0; i < pend_due.size(); i++) begin
                    if (pend_due[i] <= cycle) begin
                        if (pick == 0) begin
                            idx = i;
                            break;
                        end
                        pick--;
                    end
                end
                response_memory_in = pend_pkt[idx];
                if (pend_pkt[idx].module_id == data_module_id) exp_eng_q.push_back(pend_pkt[idx]);
                pend_pkt.delete(idx);
                pend_due.delete(idx);
            end
        end
    endtask

    // Outputs sampled and inputs driven on the falling edge
    always @(negedge ap_clk) begin
        cycle++;
        // No done while items are still on their way to the engine
        if (job_active && eng_remaining != 0) check_flag("done_out", done_out, 1'b0);
        if (request_memory_out.valid === 1'b1) accept_memory_request(request_memory_out);
        if (request_engine_out.valid === 1'b1) accept_engine_request(request_engine_out);
        send_response();
        request_memory_ready = ($urandom % 100) < cur_duty;
        request_engine_ready = ($urandom % 100) < cur_duty;
    end

    // ----------------------------------------------------------------------
    // Job sequence
    // ----------------------------------------------------------------------
    task automatic run_job(input int j);
        int unsigned k;
        int unsigned hold;
        job_t        job;
        job      = job_table[j];
        cur_job  = j;
        cur_duty = job.duty;
        // Three config reads followed by one strided read per item
        for (k = 0; k < 3; k++) begin
            exp_mem_q.push_back(make_packet(job.config_base + k, '0, config_module_id));
        end
        for (k = 0; k < job.count; k++) begin
            exp_mem_q.push_back(make_packet(job.start + k * job.stride, '0, data_module_id));
        end
        eng_remaining = job.count;
        @(negedge ap_clk);
        descriptor_in.valid       = 1'b1;
        descriptor_in.config_base = job.config_base;
        @(negedge ap_clk);
        descriptor_in = '0;
        // Done of the previous job clears once the descriptor is taken
        k = 0;
        while (done_out !== 1'b0) begin
            if (k == 8) begin
                report_problem("done_out stayed high after a new descriptor");
            end else begin
                @(negedge ap_clk);
                k++;
            end
        end
        job_active = 1'b1;
        while (done_out !== 1'b1) @(negedge ap_clk);
        job_active = 1'b0;
        check_flag("all engine requests seen", eng_remaining == 0, 1'b1);
        check_flag("all memory requests seen", exp_mem_q.size() == 0, 1'b1);
        check_flag("all memory responses sent", pend_pkt.size() == 0, 1'b1);
        // Response queue drained so memory may send again
        check_flag("response_memory_ready", response_memory_ready, 1'b1);
        // Done is a level held until the next descriptor
        hold = 3 + ($urandom % 6);
        repeat (hold) begin
            @(negedge ap_clk);
            check_flag("done_out", done_out, 1'b1);
        end
    endtask

    initial begin
        void'($urandom(32'h7178_789d));
        areset               = 1'b1;
        descriptor_in        = '0;
        response_memory_in   = '0;
        request_memory_ready = 1'b0;
        request_engine_ready = 1'b0;
        job_active           = 1'b0;
        eng_remaining        = 0;
        cycle                = 0;
        cur_duty             = 100;
        cur_job              = 0;
        repeat (5) @(negedge ap_clk);
        areset = 1'b0;
        // Quiet outputs before the first descriptor
        repeat (10) begin
            @(negedge ap_clk);
            check_flag("done_out", done_out, 1'b0);
            check_flag("request_memory_out.valid", request_memory_out.valid, 1'b0);
            check_flag("request_engine_out.valid", request_engine_out.valid, 1'b0);
        end
        for (int j = 0; j < n_jobs; j++) begin
            run_job(j);
        end
        $display("Done: no errors");
        $finish;
    end

    // Watchdog sized from the job table
    initial begin
        int unsigned limit;
        limit = 500 * n_jobs;
        foreach (job_table[j]) limit += 200 * job_table[j].count;
        repeat (limit) @(posedge ap_clk);
        report_problem($sformatf("run did not finish within %0d cycles", limit));
    end

endmodule

/* vlog.f */
hdl/read_write_pkg.sv
hdl/packet_fifo.sv
hdl/response_router.sv
hdl/config_store.sv
hdl/request_generator.sv
hdl/read_write_control.sv
hdl/engine_read_write.sv
tests/engine_read_write_tb.sv
